// File: hw/uart_pkg.sv
// UART peripheral shared definitions
// Character and bus widths, register map, parity codes and the CFG layout

package uart_pkg;

    localparam int DATA_W = 8;
    localparam int BUS_W  = 32;
    localparam int DIV_W  = 24;

    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [BUS_W-1:0]  word_t;
    typedef logic [1:0]        addr_idx_t;

    // Register word indices, from address bits 3:2
    localparam addr_idx_t ADDR_TX   = 2'd0;
    localparam addr_idx_t ADDR_RX   = 2'd1;
    localparam addr_idx_t ADDR_CFG  = 2'd2;
    localparam addr_idx_t ADDR_STAT = 2'd3;

    // Other codes behave as no parity
    typedef enum logic [2:0] {
        PARITY_OFF  = 3'd0,
        PARITY_ODD  = 3'd1,
        PARITY_EVEN = 3'd2
    } parity_e;

    // Same bit layout as the CFG register
    typedef struct packed {
        logic [3:0]       reserved;
        logic             stop_two;
        parity_e          parity;
        logic [DIV_W-1:0] divisor;
    } uart_cfg_t;

    // STATUS bit positions
    localparam int STAT_RX_AVAIL = 0;
    localparam int STAT_TX_SPACE = 1;
    localparam int STAT_PERR     = 2;

endpackage

// File: hw/uart_fifo.sv
// Byte FIFO with registered read data
// Circular buffer; pushes when full and pops when empty are dropped

module uart_fifo
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  push,
    input  byte_t din,
    input  logic  pop,
    output byte_t dout,
    output logic  empty,
    output logic  full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    byte_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign empty   = count == '0;
    assign full    = count == (PTR_W+1)'(FIFO_DEPTH);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage and read port
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// File: hw/uart_regs.sv
// UART register block
// AXI4-Lite slave holding CFG and the sticky parity flag,
// and turning TX writes and RX reads into FIFO strobes

module uart_regs
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  word_t       wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rvalid,
    input  logic        rready,
    output uart_cfg_t   cfg,
    output logic        tx_push,
    output byte_t       tx_push_data,
    input  logic        tx_full,
    output logic        rx_pop,
    input  byte_t       rx_data,
    input  logic        rx_empty,
    input  logic        parity_fail
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WDATA,
        S_WRESP,
        S_RISSUE,
        S_RLATCH,
        S_RBACK
    } state_e;

    state_e    state;
    addr_idx_t addr_q;
    word_t     wdata_q;
    logic [3:0] wstrb_q;
    word_t     rdata_q;
    word_t     strb_mask;
    word_t     status;
    logic      perr;
    logic      wr_commit;

    assign awready = state == S_IDLE;
    assign arready = state == S_IDLE;
    assign wready  = state == S_WDATA;
    assign bvalid  = state == S_WRESP;
    assign rvalid  = state == S_RBACK;
    assign rdata   = rdata_q;

    assign strb_mask = {{8{wstrb_q[3]}}, {8{wstrb_q[2]}}, {8{wstrb_q[1]}}, {8{wstrb_q[0]}}};

    // Writes take effect on the response handshake
    assign wr_commit    = state == S_WRESP && bready;
    assign tx_push      = wr_commit && addr_q == ADDR_TX && wstrb_q[0];
    assign tx_push_data = wdata_q[7:0];
    assign rx_pop       = state == S_RISSUE && addr_q == ADDR_RX;

    always_comb begin
        status                = '0;
        status[STAT_RX_AVAIL] = !rx_empty;
        status[STAT_TX_SPACE] = !tx_full;
        status[STAT_PERR]     = perr;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    // Write address wins over a read in the same cycle
                    if (awvalid) begin
                        state <= S_WDATA;
                    end else if (arvalid) begin
                        state <= S_RISSUE;
                    end
                end
                S_WDATA:  if (wvalid) state <= S_WRESP;
                S_WRESP:  if (bready) state <= S_IDLE;
                S_RISSUE: state <= S_RLATCH;
                S_RLATCH: state <= S_RBACK;
                S_RBACK:  if (rready) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Captured address, write payload and read result
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            addr_q <= awvalid ? awaddr[3:2] : araddr[3:2];
        end
        if (state == S_WDATA && wvalid) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (state == S_RLATCH) begin
            case (addr_q)
                ADDR_RX:   rdata_q <= word_t'(rx_data);
                ADDR_CFG:  rdata_q <= word_t'(cfg);
                ADDR_STAT: rdata_q <= status;
                default:   rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg  <= '0;
            perr <= 1'b0;
        end else begin
            if (wr_commit && addr_q == ADDR_CFG) begin
                cfg <= uart_cfg_t'((wdata_q & strb_mask) | (word_t'(cfg) & ~strb_mask));
            end
            if (wr_commit && addr_q == ADDR_STAT && wstrb_q[0] && !wdata_q[STAT_PERR]) begin
                perr <= 1'b0;
            end
            // A new failure outranks a clear in the same cycle
            if (parity_fail) begin
                perr <= 1'b1;
            end
        end
    end

endmodule

// File: hw/uart_tx.sv
// UART transmitter
// Fetches bytes from the TX FIFO and serializes start, data,
// optional parity and stop bits, LSB first

module uart_tx
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  uart_cfg_t cfg,
    input  byte_t     fifo_data,
    input  logic      fifo_empty,
    output logic      fifo_pop,
    output logic      tx
);

    typedef enum logic [2:0] {
        T_IDLE,
        T_START,
        T_DATA,
        T_PARITY,
        T_STOP,
        T_GAP
    } tx_state_e;

    tx_state_e        state;
    logic [DIV_W-1:0] baud_cnt;
    logic             tick;
    logic [2:0]       bit_cnt;
    logic [8:0]       shift;
    byte_t            held;
    logic             held_valid;
    logic             pop_wait;
    logic             par_on;
    logic             par_bit;

    assign par_on = cfg.parity == PARITY_ODD || cfg.parity == PARITY_EVEN;
    // Odd makes the total count of ones odd
    assign par_bit = (cfg.parity == PARITY_ODD) ? ~^held : ^held;

    assign fifo_pop = !held_valid && !pop_wait && !fifo_empty;
    assign tick     = baud_cnt == cfg.divisor - 1'b1;

    // Fetch sequencer; dout is valid one cycle after the pop
    always_ff @(posedge clk) begin
        if (!rstn) begin
            held_valid <= 1'b0;
            pop_wait   <= 1'b0;
        end else begin
            pop_wait <= fifo_pop;
            if (pop_wait) begin
                held_valid <= 1'b1;
            end else if (state == T_IDLE) begin
                held_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_wait) begin
            held <= fifo_data;
        end
    end

    // Baud counter runs only inside a frame
    always_ff @(posedge clk) begin
        if (!rstn || state == T_IDLE || tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= T_IDLE;
            tx      <= 1'b1;
            bit_cnt <= '0;
        end else begin
            case (state)
                T_IDLE: begin
                    if (held_valid) begin
                        shift   <= {par_bit, held};
                        tx      <= 1'b0;
                        bit_cnt <= '0;
                        state   <= T_START;
                    end
                end
                T_START: begin
                    if (tick) begin
                        tx    <= shift[0];
                        shift <= shift >> 1;
                        state <= T_DATA;
                    end
                end
                T_DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7 && !par_on) begin
                            tx    <= 1'b1;
                            state <= T_STOP;
                        end else begin
                            tx    <= shift[0];
                            shift <= shift >> 1;
                            if (bit_cnt == 3'd7) begin
                                state <= T_PARITY;
                            end
                        end
                    end
                end
                T_PARITY: begin
                    if (tick) begin
                        tx    <= 1'b1;
                        state <= T_STOP;
                    end
                end
                T_STOP: begin
                    // bit_cnt wrapped to 0 leaving the data bits
                    if (tick) begin
                        if (cfg.stop_two && bit_cnt == 3'd0) begin
                            bit_cnt <= 3'd1;
                        end else begin
                            state <= T_GAP;
                        end
                    end
                end
                T_GAP:   if (tick) state <= T_IDLE;
                default: state <= T_IDLE;
            endcase
        end
    end

endmodule

// File: hw/uart_rx.sv
// UART receiver
// Synchronizes rx, detects start edges, samples each bit at mid period
// and checks parity before handing the byte to the RX FIFO

module uart_rx
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  uart_cfg_t cfg,
    input  logic      rx,
    output logic      rx_push,
    output byte_t     rx_data,
    output logic      parity_fail
);

    typedef enum logic [2:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_PARITY,
        R_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [3:0]       sync;
    logic             rx_s;
    logic             fall;
    logic [DIV_W-1:0] baud_cnt;
    logic             mid;
    logic             wrap;
    logic [2:0]       bit_cnt;
    logic [8:0]       shift;
    logic             par_on;
    logic             par_bad;

    assign rx_s = sync[3];
    assign fall = sync[3] && !sync[2];
    assign mid  = baud_cnt == (cfg.divisor >> 1);
    assign wrap = baud_cnt == cfg.divisor - 1'b1;

    assign par_on  = cfg.parity == PARITY_ODD || cfg.parity == PARITY_EVEN;
    assign par_bad = (cfg.parity == PARITY_ODD && !(^shift))
                  || (cfg.parity == PARITY_EVEN && (^shift));

    assign rx_data = shift[7:0];

    // Four stage input synchronizer, idles high
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sync <= '1;
        end else begin
            sync <= {sync[2:0], rx};
        end
    end

    // Bit period counter, restarted by each start edge
    always_ff @(posedge clk) begin
        if (!rstn || state == R_IDLE || wrap) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= R_IDLE;
            bit_cnt     <= '0;
            rx_push     <= 1'b0;
            parity_fail <= 1'b0;
        end else begin
            rx_push     <= 1'b0;
            parity_fail <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (fall) begin
                        bit_cnt <= '0;
                        state   <= R_START;
                    end
                end
                R_START:  if (mid) state <= R_DATA;
                R_DATA: begin
                    if (mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7 && !par_on) begin
                            // Extra shift lines the byte up at bit 0
                            shift <= {1'b0, rx_s, shift[8:2]};
                            state <= R_STOP;
                        end else begin
                            shift <= {rx_s, shift[8:1]};
                            if (bit_cnt == 3'd7) begin
                                state <= R_PARITY;
                            end
                        end
                    end
                end
                R_PARITY: begin
                    if (mid) begin
                        shift <= {rx_s, shift[8:1]};
                        state <= R_STOP;
                    end
                end
                R_STOP: begin
                    if (mid) begin
                        if (cfg.stop_two && bit_cnt == 3'd0) begin
                            bit_cnt <= 3'd1;
                        end else begin
                            rx_push     <= !par_bad;
                            parity_fail <= par_bad;
                            state       <= R_IDLE;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

endmodule

// File: hw/uart_axi.sv
// UART peripheral top level
// Register block, TX and RX FIFOs and both serial paths

module uart_axi
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  word_t       wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rvalid,
    input  logic        rready,
    input  logic        rx,
    output logic        tx
);

    uart_cfg_t cfg;
    logic      tx_push;
    byte_t     tx_push_data;
    logic      tx_full;
    logic      tx_empty;
    logic      tx_pop;
    byte_t     tx_dout;
    logic      rx_push;
    byte_t     rx_din;
    logic      rx_pop;
    byte_t     rx_dout;
    logic      rx_empty;
    logic      parity_fail;

    uart_regs regs_i (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .cfg(cfg),
        .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_full(tx_full),
        .rx_pop(rx_pop), .rx_data(rx_dout), .rx_empty(rx_empty),
        .parity_fail(parity_fail)
    );

    uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
        .clk(clk), .rstn(rstn),
        .push(tx_push), .din(tx_push_data),
        .pop(tx_pop), .dout(tx_dout),
        .empty(tx_empty), .full(tx_full)
    );

    // New bytes are dropped inside the RX FIFO when it is full
    uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .clk(clk), .rstn(rstn),
        .push(rx_push), .din(rx_din),
        .pop(rx_pop), .dout(rx_dout),
        .empty(rx_empty), .full()
    );

    uart_tx tx_i (
        .clk(clk), .rstn(rstn), .cfg(cfg),
        .fifo_data(tx_dout), .fifo_empty(tx_empty), .fifo_pop(tx_pop),
        .tx(tx)
    );

    uart_rx rx_i (
        .clk(clk), .rstn(rstn), .cfg(cfg), .rx(rx),
        .rx_push(rx_push), .rx_data(rx_din), .parity_fail(parity_fail)
    );

endmodule

// File: tests/uart_axi_chk.sv
// AXI handshake and serial line checks for the UART top level
// Bound into uart_axi, failures counted for the testbench summary

module uart_axi_chk
    import uart_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  awready,
    input logic  bvalid,
    input logic  bready,
    input logic  rvalid,
    input logic  rready,
    input word_t rdata,
    input logic  tx
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;
    logic in_reset = 1'b0;

    // Set when rstn was low at the previous edge
    always @(posedge clk) begin
        in_reset <= !rstn;
    end

    bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

    rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> $stable(rdata))
    else begin
        $error("rdata changed while rvalid waited");
        fail_count++;
    end

    // Idle state only, so no overlap with a pending response
    aw_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        !(awready && (bvalid || rvalid)))
    else begin
        $error("awready high during a response");
        fail_count++;
    end

    tx_idle_in_reset: assert property (@(posedge clk)
        in_reset && !rstn |-> tx)
    else begin
        $error("tx low while in reset");
        fail_count++;
    end

endmodule

bind uart_axi uart_axi_chk chk_i (.*);

// File: tests/uart_axi_tb.sv
// UART peripheral testbench
// Directed tests over AXI4-Lite and the serial pins of uart_axi

module uart_axi_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT       = 200;
    localparam int FRAME_TIMEOUT = 2000;

    logic        clk;
    logic        rstn;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    word_t       wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic        rvalid;
    logic        rready;
    logic        rx;
    logic        tx;
    logic [15:0] lfsr_state = 16'd69;

    uart_axi #(.FIFO_DEPTH(16)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic byte_t rand_byte();
        byte_t v;
        for (int i = 0; i < DATA_W; i++) begin
            v[i] = next_rand_bit();
        end
        return v;
    endfunction

    // Parity bit that makes the count of ones odd or even
    function automatic logic expected_parity(input byte_t d, input parity_e par);
        int ones;
        ones = 0;
        for (int i = 0; i < DATA_W; i++) begin
            ones += d[i];
        end
        if (par == PARITY_ODD) begin
            return (ones % 2) == 0;
        end
        return (ones % 2) == 1;
    endfunction

    function automatic word_t cfg_word(input int div, input parity_e par, input logic two);
        return {4'h0, two, par, DIV_W'(div)};
    endfunction

    task automatic axi_write(input addr_idx_t idx, input word_t data, input logic [3:0] strb);
        int n;
        @(negedge clk);
        awaddr  = {8'h00, idx, 2'b00};
        awvalid = 1'b1;
        n = 0;
        while (!awready) begin
            n++;
            if (n > TIMEOUT) stop_on_timeout("awready");
            @(negedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        n = 0;
        while (!wready) begin
            n++;
            if (n > TIMEOUT) stop_on_timeout("wready");
            @(negedge clk);
        end
        @(negedge clk);
        wvalid = 1'b0;
        n = 0;
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) stop_on_timeout("bvalid");
            @(negedge clk);
        end
        // Response waits one cycle before bready
        @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_idx_t idx, output word_t data);
        int n;
        @(negedge clk);
        araddr  = {4'h0, idx, 2'b00};
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            n++;
            if (n > TIMEOUT) stop_on_timeout("arready");
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT) stop_on_timeout("rvalid");
            @(negedge clk);
        end
        data = rdata;
        // Read data waits one cycle before rready
        @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_status_bit(input int pos);
        word_t st;
        int    n;
        n = 0;
        axi_read(ADDR_STAT, st);
        while (!st[pos]) begin
            n++;
            if (n > TIMEOUT) stop_on_timeout($sformatf("STATUS bit %0d", pos));
            axi_read(ADDR_STAT, st);
        end
    endtask

    // One frame on rx, followed by one idle bit time
    task automatic uart_send(input byte_t d, input parity_e par, input logic two,
                             input logic flip, input int div);
        @(negedge clk);
        rx = 1'b0;
        repeat (div) @(negedge clk);
        for (int i = 0; i < DATA_W; i++) begin
            rx = d[i];
            repeat (div) @(negedge clk);
        end
        if (par != PARITY_OFF) begin
            rx = expected_parity(d, par) ^ flip;
            repeat (div) @(negedge clk);
        end
        rx = 1'b1;
        repeat ((two ? 3 : 2) * div) @(negedge clk);
    endtask

    // Finds the start edge, then samples every bit at its midpoint
    task automatic uart_expect(input byte_t exp, input parity_e par, input logic two,
                               input int div);
        int n;
        n = 0;
        while (tx !== 1'b0) begin
            n++;
            if (n > FRAME_TIMEOUT) stop_on_timeout("tx start bit");
            @(negedge clk);
        end
        repeat (div / 2) @(negedge clk);
        check_bit("tx start", tx, 1'b0);
        for (int i = 0; i < DATA_W; i++) begin
            repeat (div) @(negedge clk);
            check_bit($sformatf("tx data bit %0d", i), tx, exp[i]);
        end
        if (par != PARITY_OFF) begin
            repeat (div) @(negedge clk);
            check_bit("tx parity", tx, expected_parity(exp, par));
        end
        repeat (div) @(negedge clk);
        check_bit("tx stop", tx, 1'b1);
        if (two) begin
            repeat (div) @(negedge clk);
            check_bit("tx second stop", tx, 1'b1);
        end
    endtask

    task automatic read_reset_values();
        word_t got;
        axi_read(ADDR_STAT, got);
        check_word("STATUS", got, 32'h0000_0002);
        axi_read(ADDR_CFG, got);
        check_word("CFG", got, 32'h0000_0000);
        check_bit("tx", tx, 1'b1);
    endtask

    task automatic merge_cfg_strobes();
        word_t got;
        axi_write(ADDR_CFG, 32'h1234_5678, 4'hF);
        axi_write(ADDR_CFG, 32'hA5B6_C7D8, 4'b1010);
        axi_read(ADDR_CFG, got);
        // Lanes 3 and 1 from the second write
        check_word("CFG", got, 32'hA534_C778);
    endtask

    task automatic send_tx_bytes(input parity_e par, input logic two);
        byte_t sent[4];
        for (int i = 0; i < 4; i++) begin
            sent[i] = rand_byte();
        end
        axi_write(ADDR_CFG, cfg_word(8, par, two), 4'hF);
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    axi_write(ADDR_TX, word_t'(sent[i]), 4'h1);
                end
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    uart_expect(sent[i], par, two, 8);
                end
            end
        join
    endtask

    task automatic receive_rx_bytes();
        byte_t sent[4];
        word_t got;
        axi_write(ADDR_CFG, cfg_word(8, PARITY_ODD, 1'b0), 4'hF);
        for (int i = 0; i < 4; i++) begin
            sent[i] = rand_byte();
            uart_send(sent[i], PARITY_ODD, 1'b0, 1'b0, 8);
        end
        wait_status_bit(STAT_RX_AVAIL);
        for (int i = 0; i < 4; i++) begin
            axi_read(ADDR_RX, got);
            check_byte("RX data", got[7:0], sent[i]);
        end
        axi_read(ADDR_STAT, got);
        check_bit("STATUS rx_avail", got[STAT_RX_AVAIL], 1'b0);
    endtask

    task automatic drop_bad_parity();
        byte_t b;
        word_t got;
        b = rand_byte();
        uart_send(b, PARITY_ODD, 1'b0, 1'b1, 8);
        wait_status_bit(STAT_PERR);
        axi_read(ADDR_STAT, got);
        check_bit("STATUS rx_avail", got[STAT_RX_AVAIL], 1'b0);
        axi_write(ADDR_STAT, 32'h0000_0000, 4'h1);
        axi_read(ADDR_STAT, got);
        check_bit("STATUS perr", got[STAT_PERR], 1'b0);
        b = rand_byte();
        uart_send(b, PARITY_ODD, 1'b0, 1'b0, 8);
        wait_status_bit(STAT_RX_AVAIL);
        axi_read(ADDR_RX, got);
        check_byte("RX data", got[7:0], b);
    endtask

    // Two bytes leave for the serializer, 16 fill the FIFO
    task automatic fill_tx_fifo();
        word_t got;
        axi_write(ADDR_CFG, cfg_word(1000, PARITY_OFF, 1'b0), 4'hF);
        for (int i = 0; i < 18; i++) begin
            axi_write(ADDR_TX, word_t'(rand_byte()), 4'h1);
        end
        axi_read(ADDR_STAT, got);
        check_bit("STATUS tx_space", got[STAT_TX_SPACE], 1'b0);
    endtask

    initial begin
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rx      = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        read_reset_values();
        merge_cfg_strobes();
        send_tx_bytes(PARITY_OFF, 1'b0);
        send_tx_bytes(PARITY_EVEN, 1'b1);
        receive_rx_bytes();
        drop_bad_parity();
        fill_tx_fifo();

        if (dut_i.chk_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

// File: filelist.f
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_axi.sv
tests/uart_axi_chk.sv
tests/uart_axi_tb.sv
